/* all.f */
+incdir+design
design/lsq_pkg.sv
design/lsq_ctrl.sv
design/lsq_entry_store.sv
design/dmem_model.sv
design/mem_subsystem.sv
verification/tb_clk_gen.sv
verification/mem_subsystem_assert.sv
verification/mem_subsystem_tb.sv

/* run.sh */
#!/bin/sh
# build and run the mem_subsystem testbench with Verilator
# exit status is 0 only when the simulation printed the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module mem_subsystem_tb -f all.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
rc=$?
printf '%s\n' "$out"

if [ $rc -ne 0 ]; then
  echo "simulation exited with status $rc"
  exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
  echo "result: pass"
  exit 0
fi

echo "result: fail"
exit 1

/* verification/mem_subsystem_tb.sv */
// results are matched in acceptance order; stimulus never overfills the queue, so nothing drops
`timescale 1ns/1ns
`include "lsq_macros.svh"

module mem_subsystem_tb
  import lsq_pkg::*;
();

  localparam int N_RANDOM    = 120;  // length of the random mix
  localparam int N_REQS      = 1 + 2 + `LSQ_DEPTH + 8 + N_RANDOM;
  localparam int CYCLE_LIMIT = 40 * N_REQS + 200;

  // one expected retire
  typedef struct packed {
    mem_op_e            op;
    logic [`DATA_W-1:0] data;
    logic [`CTRL_W-1:0] ctrl;
    logic [`DEST_W-1:0] dest;
  } exp_t;

  logic clk;
  logic rst;

  // core side of the DUT
  logic               req_valid;
  mem_op_e            req_op;
  logic [`DATA_W-1:0] req_addr;
  logic [`DATA_W-1:0] req_wdata;
  logic [`CTRL_W-1:0] req_ctrl;
  logic [`DEST_W-1:0] req_dest;
  logic               full;
  logic               empty;
  logic               resp_valid;
  mem_op_e            resp_op;
  logic [`DATA_W-1:0] resp_data;
  logic [`CTRL_W-1:0] resp_ctrl;
  logic [`DEST_W-1:0] resp_dest;

  logic [`DATA_W-1:0] shadow [`DMEM_WORDS];  // reference copy of data memory
  exp_t   exp_q [$];            // pending results, oldest first
  exp_t   head_exp;
  string  test_name;
  integer seed;
  int     sent_cnt;             // requests driven so far
  int     retired_cnt = 0;      // retire pulses seen
  int     occ_cnt     = 0;      // entries the DUT should hold
  int     cycle_cnt   = 0;

  tb_clk_gen u_clk_gen (
    .o_clk (clk),
    .o_rst (rst)
  );

  mem_subsystem UUT (
    .clk          (clk),
    .rst          (rst),
    .i_req_valid  (req_valid),
    .i_req_op     (req_op),
    .i_req_addr   (req_addr),
    .i_req_wdata  (req_wdata),
    .i_req_ctrl   (req_ctrl),
    .i_req_dest   (req_dest),
    .o_full       (full),
    .o_empty      (empty),
    .o_resp_valid (resp_valid),
    .o_resp_op    (resp_op),
    .o_resp_data  (resp_data),
    .o_resp_ctrl  (resp_ctrl),
    .o_resp_dest  (resp_dest)
  );

  bind lsq_ctrl mem_subsystem_assert u_assert (
    .clk           (clk),
    .rst           (rst),
    .i_req_valid   (i_req_valid),
    .i_full        (o_full),
    .i_empty       (o_empty),
    .i_retire_en   (o_retire_en),
    .i_issue_valid (o_issue_valid),
    .i_count       (count)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_val(input string name, input logic [`DATA_W-1:0] expected,
                           input logic [`DATA_W-1:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // load returns the current word, store returns its own write data
  function automatic logic [`DATA_W-1:0] ref_result(input mem_op_e op,
                                                    input logic [`DATA_W-1:0] addr,
                                                    input logic [`DATA_W-1:0] wdata);
    logic [9:0] idx;
    idx = addr[11:2];  // word index, low 4 KB
    if (op == OP_STORE) begin
      shadow[idx] = wdata;
      return wdata;
    end
    return shadow[idx];
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      req_valid <= 1'b0;
    end
  endtask

  // drive one request; holds off while the queue could be full at acceptance
  task automatic send_req(input mem_op_e op, input logic [`DATA_W-1:0] addr,
                          input logic [`DATA_W-1:0] wdata, input logic [`CTRL_W-1:0] ctrl,
                          input logic [`DEST_W-1:0] dest);
    exp_t e;
    @(negedge clk);
    while (full || (sent_cnt - retired_cnt) >= `LSQ_DEPTH) begin
      @(posedge clk);
      req_valid <= 1'b0;
      @(negedge clk);
    end
    @(posedge clk);
    req_valid <= 1'b1;
    req_op    <= op;
    req_addr  <= addr;
    req_wdata <= wdata;
    req_ctrl  <= ctrl;
    req_dest  <= dest;
    e.op   = op;
    e.data = ref_result(op, addr, wdata);  // memory sees requests in this order
    e.ctrl = ctrl;
    e.dest = dest;
    exp_q.push_back(e);
    sent_cnt++;
  endtask

  task automatic send_random(input logic [9:0] word_mask);
    logic [`DATA_W-1:0] r;
    logic [`DATA_W-1:0] wd;
    logic [9:0]         word;
    r    = $random(seed);
    wd   = $random(seed);
    word = r[17:8] & word_mask;  // narrow mask gives address reuse
    send_req(mem_op_e'(r[0]), {20'd0, word, 2'b00}, wd, r[23:20], r[27:24]);
  endtask

  // stop driving, wait for the last retire, then the queue must be empty
  task automatic wait_drain();
    idle_cycles(1);
    do begin
      @(negedge clk);
    end while (retired_cnt != sent_cnt);
    check_val({test_name, " empty after drain"}, 1, 32'(empty));
  endtask

  // occupancy from what the core sent and saw retire
  always @(posedge clk) begin
    if (rst) begin
      occ_cnt <= 0;
    end else begin
      occ_cnt <= occ_cnt + (req_valid ? 1 : 0) - (resp_valid ? 1 : 0);
    end
  end

  // comparator, outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      check_val({test_name, " full flag"}, 32'(occ_cnt == `LSQ_DEPTH), 32'(full));
      check_val({test_name, " empty flag"}, 32'(occ_cnt == 0), 32'(empty));
    end
    if (!rst && resp_valid) begin
      if (exp_q.size() == 0) begin
        abort_run("retire pulse seen with no request outstanding");
      end else begin
        head_exp = exp_q.pop_front();
        check_val({test_name, " data"}, head_exp.data, resp_data);
        check_val({test_name, " op"}, 32'(head_exp.op), 32'(resp_op));
        check_val({test_name, " ctrl"}, 32'(head_exp.ctrl), 32'(resp_ctrl));
        check_val({test_name, " dest"}, 32'(head_exp.dest), 32'(resp_dest));
        retired_cnt <= retired_cnt + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      abort_run($sformatf("timeout: run not finished after %0d cycles", cycle_cnt));
    end
  end

  initial begin
    int lat;
    int gap;
    req_valid = 1'b0;
    req_op    = OP_LOAD;
    req_addr  = '0;
    req_wdata = '0;
    req_ctrl  = '0;
    req_dest  = '0;
    seed      = 50;
    sent_cnt  = 0;
    test_name = "reset";
    for (int i = 0; i < `DMEM_WORDS; i++) begin
      shadow[i] = `DATA_W'(i);  // dmem comes out of reset holding the index
    end

    @(negedge clk);
    while (rst) begin
      @(negedge clk);
    end
    repeat (3) begin
      check_val("reset empty", 1, 32'(empty));
      check_val("reset full", 0, 32'(full));
      check_val("reset no response", 0, 32'(resp_valid));
      @(negedge clk);
    end

    // single load, fixed latency
    test_name = "isolated load";
    send_req(OP_LOAD, 32'h0000_0100, 32'h0, 4'h3, 4'h5);
    idle_cycles(1);  // this edge accepts it
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!resp_valid && lat < 20);
    check_val("isolated load latency", 4, lat - 1);
    wait_drain();

    test_name = "store then load";
    send_req(OP_STORE, 32'h0000_02A4, 32'hCAFE_0123, 4'h9, 4'h1);
    send_req(OP_LOAD, 32'h0000_02A4, 32'h0, 4'h6, 4'h2);
    wait_drain();

    // back-to-back burst, then more behind the full check
    test_name = "burst";
    repeat (`LSQ_DEPTH) begin
      send_random(10'h3FF);
    end
    repeat (8) begin
      send_random(10'h3FF);
    end
    wait_drain();

    test_name = "random mix";
    for (int n = 0; n < N_RANDOM; n++) begin
      send_random(10'h01F);
      gap = $random(seed) & 3;  // 0 keeps it back-to-back
      idle_cycles(gap);
    end
    wait_drain();

    test_name = "quiet after drain";
    repeat (20) begin
      @(negedge clk);
      check_val("no response after drain", 0, 32'(resp_valid));
    end
    check_val("empty at end", 1, 32'(empty));

    $display("** PASS **");
    $finish;
  end

endmodule

/* verification/mem_subsystem_assert.sv */
// bound into lsq_ctrl; all properties are disabled while rst is high
`timescale 1ns/1ns
`include "lsq_macros.svh"

module mem_subsystem_assert (
  input logic                  clk,
  input logic                  rst,
  input logic                  i_req_valid,
  input logic                  i_full,
  input logic                  i_empty,
  input logic                  i_retire_en,
  input logic                  i_issue_valid,
  input logic [`LSQ_CNT_W-1:0] i_count       // internal occupancy of the control
);

  logic accept;

  assign accept = i_req_valid && !i_full;  // same rule as the control

  // occupancy bound
  a_count_max: assert property (
    @(posedge clk) disable iff (rst) i_count <= `LSQ_CNT_W'(`LSQ_DEPTH)
  ) else $error("occupancy count %0d above queue depth", i_count);

  // flags are exclusive
  a_flags_excl: assert property (
    @(posedge clk) disable iff (rst) !(i_full && i_empty)
  ) else $error("full and empty flags high together");

  // nothing to retire from an empty queue
  a_no_retire_empty: assert property (
    @(posedge clk) disable iff (rst) !(i_retire_en && i_empty)
  ) else $error("retire pulse while queue is empty");

  // issue one cycle after accept, and only then
  a_issue_after_accept: assert property (
    @(posedge clk) disable iff (rst) accept |=> i_issue_valid
  ) else $error("accepted request not issued on the next cycle");

  a_issue_needs_accept: assert property (
    @(posedge clk) disable iff (rst) i_issue_valid |-> $past(accept)
  ) else $error("issue strobe without an accepted request one cycle earlier");

endmodule

/* verification/tb_clk_gen.sv */
// free-running 20 ns clock; reset is held high across the first two rising edges
`timescale 1ns/1ns

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;  // 20 ns period
  end

  initial begin
    o_rst = 1'b1;
    repeat (2) @(posedge o_clk);  // two reset edges
    o_rst <= 1'b0;
  end

endmodule

/* design/mem_subsystem.sv */
// core must hold off requests while o_full is high; isolated request retires 4 cycles after accept
`timescale 1ns/1ns
`include "lsq_macros.svh"

module mem_subsystem
  import lsq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  // core request
  input  logic                  i_req_valid,  // strobe
  input  mem_op_e               i_req_op,
  input  logic [`DATA_W-1:0]    i_req_addr,
  input  logic [`DATA_W-1:0]    i_req_wdata,
  input  logic [`CTRL_W-1:0]    i_req_ctrl,
  input  logic [`DEST_W-1:0]    i_req_dest,
  // core status and retire
  output logic                  o_full,
  output logic                  o_empty,
  output logic                  o_resp_valid, // one pulse per retired entry
  output mem_op_e               o_resp_op,
  output logic [`DATA_W-1:0]    o_resp_data,
  output logic [`CTRL_W-1:0]    o_resp_ctrl,
  output logic [`DEST_W-1:0]    o_resp_dest
);

  // control <-> entry store
  logic                  alloc_en;
  logic [`LSQ_ID_W-1:0]  alloc_id;
  logic [`LSQ_ID_W-1:0]  head_id;
  logic                  head_done;

  // issue path
  logic                  issue_valid;
  logic [`LSQ_ID_W-1:0]  issue_id;
  mem_op_e               issue_op;
  logic [`DATA_W-1:0]    issue_addr;
  logic [`DATA_W-1:0]    issue_wdata;

  // memory response
  logic                  rsp_valid;
  logic [`LSQ_ID_W-1:0]  rsp_id;
  logic [`DATA_W-1:0]    rsp_data;

  lsq_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .i_req_valid   (i_req_valid),
    .i_head_done   (head_done),
    .o_alloc_en    (alloc_en),
    .o_alloc_id    (alloc_id),
    .o_head_id     (head_id),
    .o_retire_en   (o_resp_valid),  // retire is the core pulse
    .o_issue_valid (issue_valid),
    .o_issue_id    (issue_id),
    .o_full        (o_full),
    .o_empty       (o_empty)
  );

  lsq_entry_store u_store (
    .clk           (clk),
    .rst           (rst),
    .i_alloc_en    (alloc_en),
    .i_alloc_id    (alloc_id),
    .i_req_op      (i_req_op),
    .i_req_addr    (i_req_addr),
    .i_req_wdata   (i_req_wdata),
    .i_req_ctrl    (i_req_ctrl),
    .i_req_dest    (i_req_dest),
    .i_issue_id    (issue_id),
    .o_issue_op    (issue_op),
    .o_issue_addr  (issue_addr),
    .o_issue_wdata (issue_wdata),
    .i_rsp_valid   (rsp_valid),
    .i_rsp_id      (rsp_id),
    .i_rsp_data    (rsp_data),
    .i_head_id     (head_id),
    .i_retire_en   (o_resp_valid),
    .o_head_done   (head_done),
    .o_head_op     (o_resp_op),
    .o_head_data   (o_resp_data),
    .o_head_ctrl   (o_resp_ctrl),
    .o_head_dest   (o_resp_dest)
  );

  dmem_model u_dmem (
    .clk         (clk),
    .rst         (rst),
    .i_valid     (issue_valid),
    .i_op        (issue_op),
    .i_addr      (issue_addr),
    .i_wdata     (issue_wdata),
    .i_id        (issue_id),
    .o_rsp_valid (rsp_valid),
    .o_rsp_id    (rsp_id),
    .o_rsp_data  (rsp_data)
  );

endmodule

/* design/dmem_model.sv */
// never stalls; only addr[11:2] is decoded, so addresses alias every 4 KB
`timescale 1ns/1ns
`include "lsq_macros.svh"

module dmem_model
  import lsq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_valid,     // request strobe from issue
  input  mem_op_e               i_op,
  input  logic [`DATA_W-1:0]    i_addr,
  input  logic [`DATA_W-1:0]    i_wdata,
  input  logic [`LSQ_ID_W-1:0]  i_id,        // queue slot, echoed back
  output logic                  o_rsp_valid, // pulse, 2 cycles after sampling edge
  output logic [`LSQ_ID_W-1:0]  o_rsp_id,
  output logic [`DATA_W-1:0]    o_rsp_data
);

  localparam int IDX_W = $clog2(`DMEM_WORDS);  // 10 bits of word index

  logic [`DATA_W-1:0]  mem [`DMEM_WORDS];
  logic [IDX_W-1:0]    word_idx;

  // delay pipe, [0] loads on the sampling edge
  logic                 dly_valid [2];
  logic [`LSQ_ID_W-1:0] dly_id    [2];
  logic [`DATA_W-1:0]   dly_data  [2];

  assign word_idx = i_addr[IDX_W+1:2];  // word addressed

  // array, each word comes up holding its own index
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `DMEM_WORDS; i++) begin
        mem[i] <= `DATA_W'(i);
      end
    end else if (i_valid && (i_op == OP_STORE)) begin
      mem[word_idx] <= i_wdata;
    end
  end

  // strobes of the delay pipe and output
  always_ff @(posedge clk) begin
    if (rst) begin
      dly_valid[0] <= 1'b0;
      dly_valid[1] <= 1'b0;
      o_rsp_valid  <= 1'b0;
    end else begin
      dly_valid[0] <= i_valid;
      dly_valid[1] <= dly_valid[0];
      o_rsp_valid  <= dly_valid[1];
    end
  end

  // id and data ride along
  always_ff @(posedge clk) begin
    dly_id[0]   <= i_id;
    // load reads the old word, store echoes its write data
    dly_data[0] <= (i_op == OP_STORE) ? i_wdata : mem[word_idx];
    dly_id[1]   <= dly_id[0];
    dly_data[1] <= dly_data[0];
    o_rsp_id    <= dly_id[1];
    o_rsp_data  <= dly_data[1];
  end

endmodule

/* design/lsq_entry_store.sv */
// only status is reset; payload of a free slot is stale until the next allocation
`timescale 1ns/1ns
`include "lsq_macros.svh"

module lsq_entry_store
  import lsq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  // allocation from the core side
  input  logic                  i_alloc_en,
  input  logic [`LSQ_ID_W-1:0]  i_alloc_id,
  input  mem_op_e               i_req_op,
  input  logic [`DATA_W-1:0]    i_req_addr,
  input  logic [`DATA_W-1:0]    i_req_wdata,
  input  logic [`CTRL_W-1:0]    i_req_ctrl,
  input  logic [`DEST_W-1:0]    i_req_dest,
  // issue read port
  input  logic [`LSQ_ID_W-1:0]  i_issue_id,
  output mem_op_e               o_issue_op,
  output logic [`DATA_W-1:0]    o_issue_addr,
  output logic [`DATA_W-1:0]    o_issue_wdata,
  // memory response
  input  logic                  i_rsp_valid,
  input  logic [`LSQ_ID_W-1:0]  i_rsp_id,
  input  logic [`DATA_W-1:0]    i_rsp_data,
  // head read port and retire
  input  logic [`LSQ_ID_W-1:0]  i_head_id,
  input  logic                  i_retire_en,
  output logic                  o_head_done,
  output mem_op_e               o_head_op,
  output logic [`DATA_W-1:0]    o_head_data,
  output logic [`CTRL_W-1:0]    o_head_ctrl,
  output logic [`DEST_W-1:0]    o_head_dest
);

  // parallel per-entry arrays
  mem_op_e            op_q    [`LSQ_DEPTH];
  logic [`DATA_W-1:0] addr_q  [`LSQ_DEPTH];
  logic [`DATA_W-1:0] data_q  [`LSQ_DEPTH];  // wdata, then response data
  logic [`CTRL_W-1:0] ctrl_q  [`LSQ_DEPTH];
  logic [`DEST_W-1:0] dest_q  [`LSQ_DEPTH];
  entry_state_e       state_q [`LSQ_DEPTH];

  // entry status
  // retire, response and alloc never hit the same slot in one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `LSQ_DEPTH; i++) begin
        state_q[i] <= ENT_FREE;
      end
    end else begin
      if (i_retire_en) begin
        state_q[i_head_id] <= ENT_FREE;   // head leaves
      end
      if (i_rsp_valid) begin
        state_q[i_rsp_id] <= ENT_DONE;    // seen at head next cycle
      end
      if (i_alloc_en) begin
        state_q[i_alloc_id] <= ENT_WAIT;
      end
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (i_alloc_en) begin
      op_q[i_alloc_id]   <= i_req_op;
      addr_q[i_alloc_id] <= i_req_addr;
      data_q[i_alloc_id] <= i_req_wdata;  // held until issue reads it
      ctrl_q[i_alloc_id] <= i_req_ctrl;
      dest_q[i_alloc_id] <= i_req_dest;
    end
    if (i_rsp_valid) begin
      data_q[i_rsp_id] <= i_rsp_data;  // load word or echoed store data
    end
  end

  // issue port, read the cycle after alloc
  assign o_issue_op    = op_q[i_issue_id];
  assign o_issue_addr  = addr_q[i_issue_id];
  assign o_issue_wdata = data_q[i_issue_id];

  // head port
  assign o_head_done = (state_q[i_head_id] == ENT_DONE);
  assign o_head_op   = op_q[i_head_id];
  assign o_head_data = data_q[i_head_id];
  assign o_head_ctrl = ctrl_q[i_head_id];
  assign o_head_dest = dest_q[i_head_id];

endmodule

/* design/lsq_ctrl.sv */
// requests that arrive while o_full is high are dropped; issue follows acceptance by one cycle
`timescale 1ns/1ns
`include "lsq_macros.svh"

module lsq_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_req_valid,    // core strobe, one per request
  input  logic                  i_head_done,    // oldest entry has its response
  output logic                  o_alloc_en,     // write request into tail slot
  output logic [`LSQ_ID_W-1:0]  o_alloc_id,
  output logic [`LSQ_ID_W-1:0]  o_head_id,
  output logic                  o_retire_en,    // frees head, also the core pulse
  output logic                  o_issue_valid,  // to memory, one cycle after accept
  output logic [`LSQ_ID_W-1:0]  o_issue_id,
  output logic                  o_full,
  output logic                  o_empty
);

  logic [`LSQ_ID_W-1:0]  tail_ptr;  // next slot to allocate
  logic [`LSQ_ID_W-1:0]  head_ptr;  // oldest live entry
  logic [`LSQ_CNT_W-1:0] count;     // live entries
  logic                  accept;

  // flags straight off the count
  assign o_full  = (count == `LSQ_DEPTH);
  assign o_empty = (count == 0);

  assign accept = i_req_valid && !o_full;  // drop when full

  assign o_alloc_en = accept;
  assign o_alloc_id = tail_ptr;
  assign o_head_id  = head_ptr;

  // in-order retire, at most one per cycle
  // head_done is never set on an empty queue since all slots are free
  assign o_retire_en = i_head_done;

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      tail_ptr <= '0;
      head_ptr <= '0;
    end else begin
      if (accept) begin
        tail_ptr <= tail_ptr + `LSQ_ID_W'(1);
      end
      if (o_retire_en) begin
        head_ptr <= head_ptr + `LSQ_ID_W'(1);
      end
    end
  end

  // occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({accept, o_retire_en})
        2'b10:   count <= count + `LSQ_CNT_W'(1);  // alloc only
        2'b01:   count <= count - `LSQ_CNT_W'(1);  // retire only
        default: count <= count;                   // both or neither
      endcase
    end
  end

  // issue strobe, the slot was written at the accepting edge
  always_ff @(posedge clk) begin
    if (rst) begin
      o_issue_valid <= 1'b0;
    end else begin
      o_issue_valid <= accept;
    end
  end

  // id only matters while the strobe is high
  always_ff @(posedge clk) begin
    if (accept) begin
      o_issue_id <= tail_ptr;
    end
  end

endmodule

/* design/lsq_pkg.sv */
// shared types only; widths of the enums are fixed and match the memory and entry encodings
package lsq_pkg;

  // request opcode, carried with each entry
  typedef enum logic {
    OP_LOAD  = 1'b0,  // read word
    OP_STORE = 1'b1   // write word, response echoes write data
  } mem_op_e;

  // status of one queue entry
  // free -> wait on alloc, wait -> done on response, done -> free on retire
  typedef enum logic [1:0] {
    ENT_FREE = 2'b00,  // slot unused
    ENT_WAIT = 2'b01,  // issued or about to issue, no response yet
    ENT_DONE = 2'b10   // response written, waiting to reach head
  } entry_state_e;

endpackage

/* design/lsq_macros.svh */
// sizes are tied together; depth must equal 2**LSQ_ID_W and the count needs one extra bit
`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

// queue geometry
`define LSQ_DEPTH 16   // entries in the load/store queue
`define LSQ_ID_W 4     // entry id, echoed back by memory
`define LSQ_CNT_W 5    // occupancy 0..16

// datapath
`define DATA_W 32      // address and data width
`define CTRL_W 4       // writeback control bits carried to retire
`define DEST_W 4       // destination register number

// data memory
// word index is addr[11:2], so only the low 4 KB is decoded
`define DMEM_WORDS 1024

`endif
